//--- include/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// machine word width, rv32 only
`define XLEN 32

// reorder buffer depth and the tag that indexes it
`define ROB_SIZE 16
`define ROB_TAG_WIDTH 4

// reservation stations per class
`define N_ALU_RS 3
`define N_AGU_RS 2
`define N_BRANCH_RS 2

`endif

//--- src/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

`include "dispatch_consts.svh"

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`ROB_TAG_WIDTH-1:0] rob_tag_t;
	typedef logic [4:0] reg_idx_t;

	// base opcodes of the supported subset
	// nop is the all-zero bubble the decode stage inserts
	typedef enum logic [6:0] {
		NOP    = 7'b0000000,
		R_TYPE = 7'b0110011,
		I_ALU  = 7'b0010011,
		LOAD   = 7'b0000011,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		STORE  = 7'b0100011,
		JAL    = 7'b1101111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_e;

	// r, i, s and b formats share this field layout
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} rsi_fmt_t;

	// u and j formats carry a 20 bit upper field
	typedef struct packed {
		logic [19:0] imm_hi;
		reg_idx_t rd;
		logic [6:0] opcode;
	} uj_fmt_t;

	typedef union packed {
		rsi_fmt_t rsi;
		uj_fmt_t uj;
	} instr_word_u;

	// control word held in the decode stage register
	typedef struct packed {
		logic valid;
		opcode_e opcode;
		// 00 alu, 01 branch or jump, 10 load, 11 store
		logic [1:0] instruction_type;
		logic ctl_branch;
		logic ctl_jalr;
		logic ctl_u_type;
		logic lui;
		logic auipc;
		logic ctl_alloc_rob_entry;
		logic ctl_alloc_ldq_entry;
		logic ctl_alloc_stq_entry;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t pc;
		word_t immediate;
		// 1 for a 4 byte word, 0 for a compressed one
		logic instruction_length;
	} decoded_t;

	typedef struct packed {
		logic q1_valid;
		rob_tag_t q1;
		word_t v1;
		logic q2_valid;
		rob_tag_t q2;
		word_t v2;
	} operands_t;

	typedef struct packed {
		word_t value;
		logic data_ready;
	} rob_entry_t;

	typedef struct packed {
		word_t value;
		rob_tag_t rob_tag;
		logic tag_valid;
	} reg_read_t;

endpackage

`default_nettype wire

//--- src/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module instr_decode (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input dispatch_pkg::instr_word_u instr,
	input dispatch_pkg::word_t pc,
	input logic instr_length,
	input logic stall,
	input logic flush,
	output dispatch_pkg::decoded_t stage_q
);

	import dispatch_pkg::*;

	decoded_t next_stage;

	// immediates for every format, picked by opcode below
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign imm_i = {{20{instr.rsi.funct7[6]}}, instr.rsi.funct7, instr.rsi.rs2};
	assign imm_s = {{20{instr.rsi.funct7[6]}}, instr.rsi.funct7, instr.rsi.rd};
	// b format scatters bit 11 into the low rd bit
	assign imm_b = {{19{instr.rsi.funct7[6]}}, instr.rsi.funct7[6], instr.rsi.rd[0],
		instr.rsi.funct7[5:0], instr.rsi.rd[4:1], 1'b0};
	assign imm_u = {instr.uj.imm_hi, 12'b0};
	// same word seen as u/j, bits reshuffled for the jump offset
	assign imm_j = {{11{instr.uj.imm_hi[19]}}, instr.uj.imm_hi[19], instr.uj.imm_hi[7:0],
		instr.uj.imm_hi[8], instr.uj.imm_hi[18:9], 1'b0};

	always_comb begin
		next_stage = '0;
		next_stage.valid = instr_valid;
		next_stage.pc = pc;
		next_stage.instruction_length = instr_length;
		// every real instruction takes a rob entry
		next_stage.ctl_alloc_rob_entry = 1'b1;
		case (instr.rsi.opcode)
			R_TYPE: begin
				next_stage.opcode = R_TYPE;
				next_stage.rd = instr.rsi.rd;
				next_stage.rs1 = instr.rsi.rs1;
				next_stage.rs2 = instr.rsi.rs2;
			end
			I_ALU: begin
				next_stage.opcode = I_ALU;
				next_stage.rd = instr.rsi.rd;
				next_stage.rs1 = instr.rsi.rs1;
				next_stage.immediate = imm_i;
			end
			LOAD: begin
				next_stage.opcode = LOAD;
				next_stage.instruction_type = 2'b10;
				next_stage.ctl_alloc_ldq_entry = 1'b1;
				next_stage.rd = instr.rsi.rd;
				next_stage.rs1 = instr.rsi.rs1;
				next_stage.immediate = imm_i;
			end
			JALR: begin
				next_stage.opcode = JALR;
				next_stage.instruction_type = 2'b01;
				next_stage.ctl_jalr = 1'b1;
				next_stage.rd = instr.rsi.rd;
				next_stage.rs1 = instr.rsi.rs1;
				next_stage.immediate = imm_i;
			end
			BRANCH: begin
				// rd bits hold offset here, so no destination
				next_stage.opcode = BRANCH;
				next_stage.instruction_type = 2'b01;
				next_stage.ctl_branch = 1'b1;
				next_stage.rs1 = instr.rsi.rs1;
				next_stage.rs2 = instr.rsi.rs2;
				next_stage.immediate = imm_b;
			end
			STORE: begin
				next_stage.opcode = STORE;
				next_stage.instruction_type = 2'b11;
				next_stage.ctl_alloc_stq_entry = 1'b1;
				next_stage.rs1 = instr.rsi.rs1;
				next_stage.rs2 = instr.rsi.rs2;
				next_stage.immediate = imm_s;
			end
			JAL: begin
				next_stage.opcode = JAL;
				next_stage.instruction_type = 2'b01;
				next_stage.rd = instr.uj.rd;
				next_stage.immediate = imm_j;
			end
			LUI: begin
				next_stage.opcode = LUI;
				next_stage.ctl_u_type = 1'b1;
				next_stage.lui = 1'b1;
				next_stage.rd = instr.uj.rd;
				next_stage.immediate = imm_u;
			end
			AUIPC: begin
				next_stage.opcode = AUIPC;
				next_stage.ctl_u_type = 1'b1;
				next_stage.auipc = 1'b1;
				next_stage.rd = instr.uj.rd;
				next_stage.immediate = imm_u;
			end
			default: begin
				next_stage.valid = 1'b0;
			end
		endcase
		// empty slot or unknown opcode becomes a clean nop bubble
		if (!next_stage.valid) begin
			next_stage = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_q <= '0;
		end else if (flush) begin
			stage_q.valid <= 1'b0;
		end else if (!stall) begin
			stage_q <= next_stage;
		end
	end

	// a word with an opcode outside the subset must never reach the route stage
	unknown_opcode_never_valid: assert property (@(posedge clk) disable iff (reset)
		(!stall && !flush
			&& !(instr.rsi.opcode inside {R_TYPE, I_ALU, LOAD, JALR, BRANCH,
				STORE, JAL, LUI, AUIPC}))
		|=> !stage_q.valid);

endmodule

`default_nettype wire

//--- src/reg_status_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module reg_status_file (
	input logic clk,
	input logic reset,
	input logic flush,
	input dispatch_pkg::decoded_t stage_q,
	input logic alloc_rob_entry,
	input dispatch_pkg::rob_tag_t rob_tail_tag,
	input logic commit_valid,
	input dispatch_pkg::reg_idx_t commit_rd,
	input dispatch_pkg::rob_tag_t commit_tag,
	input dispatch_pkg::word_t commit_value,
	output dispatch_pkg::reg_read_t rs1_read,
	output dispatch_pkg::reg_read_t rs2_read
);

	import dispatch_pkg::*;

	// architectural values and the rob entry that will produce each one
	word_t reg_value [32];
	rob_tag_t reg_tag [32];
	logic [31:0] tag_valid;

	logic alloc_rd;
	logic commit_hit;

	// x0 is never renamed
	assign alloc_rd = alloc_rob_entry && (stage_q.rd != '0);
	// only the youngest producer may clear the tag
	assign commit_hit = commit_valid && tag_valid[commit_rd]
		&& (reg_tag[commit_rd] == commit_tag);

	always_ff @(posedge clk) begin
		if (commit_valid && (commit_rd != '0)) begin
			reg_value[commit_rd] <= commit_value;
		end
		if (alloc_rd) begin
			reg_tag[stage_q.rd] <= rob_tail_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			tag_valid <= '0;
		end else begin
			if (commit_hit) begin
				tag_valid[commit_rd] <= 1'b0;
			end
			// later assignment, so a same-cycle allocation keeps the new tag
			if (alloc_rd) begin
				tag_valid[stage_q.rd] <= 1'b1;
			end
		end
	end

	function automatic reg_read_t read_reg(input reg_idx_t idx);
		reg_read_t r;
		r.value = reg_value[idx];
		r.rob_tag = reg_tag[idx];
		r.tag_valid = tag_valid[idx];
		// x0 reads as a plain zero
		if (idx == '0) begin
			r = '0;
		end
		return r;
	endfunction

	always_comb begin
		rs1_read = read_reg(stage_q.rs1);
		rs2_read = read_reg(stage_q.rs2);
	end

	x0_never_tagged: assert property (@(posedge clk) disable iff (reset) !tag_valid[0]);

endmodule

`default_nettype wire

//--- src/instruction_route.sv
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module instruction_route (
	input dispatch_pkg::decoded_t stage_q,
	input logic rob_full,
	input logic ldq_full,
	input logic stq_full,
	input logic flush,
	input logic [`N_ALU_RS-1:0] alu_rs_busy,
	input logic [`N_AGU_RS-1:0] agu_rs_busy,
	input logic [`N_BRANCH_RS-1:0] branch_rs_busy,
	output logic alloc_rob_entry,
	output logic alloc_ldq_entry,
	output logic alloc_stq_entry,
	output logic [`N_ALU_RS-1:0] alu_rs_route,
	output logic [`N_AGU_RS-1:0] agu_rs_route,
	output logic [`N_BRANCH_RS-1:0] branch_rs_route,
	output logic stall
);

	// common width wide enough for the largest station class
	localparam int RS_W_AB = (`N_ALU_RS > `N_AGU_RS) ? `N_ALU_RS : `N_AGU_RS;
	localparam int RS_W = (RS_W_AB > `N_BRANCH_RS) ? RS_W_AB : `N_BRANCH_RS;

	// lsb fixed priority, isolates the lowest set bit
	function automatic logic [RS_W-1:0] lowest_free(input logic [RS_W-1:0] free);
		return free & (~free + RS_W'(1));
	endfunction

	logic rs_type_alu;
	logic rs_type_agu;
	logic rs_type_branch;

	// lui and auipc already have their value, they go straight to the rob
	assign rs_type_alu = (stage_q.instruction_type == 2'b00) && !stage_q.ctl_u_type;
	assign rs_type_agu = stage_q.instruction_type[1];
	// jal has nothing left to execute
	assign rs_type_branch = (stage_q.instruction_type == 2'b01)
		&& (stage_q.ctl_jalr || stage_q.ctl_branch);

	logic [`N_ALU_RS-1:0] alu_free;
	logic [`N_AGU_RS-1:0] agu_free;
	logic [`N_BRANCH_RS-1:0] branch_free;
	logic [RS_W-1:0] alu_pick;
	logic [RS_W-1:0] agu_pick;
	logic [RS_W-1:0] branch_pick;

	assign alu_free = ~alu_rs_busy;
	assign agu_free = ~agu_rs_busy;
	assign branch_free = ~branch_rs_busy;
	assign alu_pick = lowest_free(RS_W'(alu_free));
	assign agu_pick = lowest_free(RS_W'(agu_free));
	assign branch_pick = lowest_free(RS_W'(branch_free));

	logic stall_any;
	logic issue_ok;

	// every reason to hold, before valid is applied
	assign stall_any = (stage_q.ctl_alloc_rob_entry && rob_full)
		|| (stage_q.ctl_alloc_ldq_entry && ldq_full)
		|| (stage_q.ctl_alloc_stq_entry && stq_full)
		|| (rs_type_alu && (&alu_rs_busy))
		|| (rs_type_agu && (&agu_rs_busy))
		|| (rs_type_branch && (&branch_rs_busy));

	assign issue_ok = !flush && !stall_any;

	// valid joins only at the end of each chain
	assign stall = stage_q.valid && stall_any;

	assign alloc_rob_entry = stage_q.valid && (stage_q.ctl_alloc_rob_entry && issue_ok);
	assign alloc_ldq_entry = stage_q.valid && (stage_q.ctl_alloc_ldq_entry && issue_ok);
	assign alloc_stq_entry = stage_q.valid && (stage_q.ctl_alloc_stq_entry && issue_ok);

	assign alu_rs_route = alu_pick[`N_ALU_RS-1:0]
		& {`N_ALU_RS{rs_type_alu && issue_ok && stage_q.valid}};
	assign agu_rs_route = agu_pick[`N_AGU_RS-1:0]
		& {`N_AGU_RS{rs_type_agu && issue_ok && stage_q.valid}};
	assign branch_rs_route = branch_pick[`N_BRANCH_RS-1:0]
		& {`N_BRANCH_RS{rs_type_branch && issue_ok && stage_q.valid}};

endmodule

`default_nettype wire

//--- src/operand_route.sv
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module operand_route (
	input dispatch_pkg::decoded_t stage_q,
	input dispatch_pkg::reg_read_t rs1_read,
	input dispatch_pkg::reg_read_t rs2_read,
	input logic [`ROB_SIZE-1:0][`XLEN-1:0] rob_value,
	input logic [`ROB_SIZE-1:0] rob_data_ready,
	output dispatch_pkg::operands_t operands
);

	import dispatch_pkg::*;

	// resolve one source against the rob
	// tag_valid in the result means the station must still wait on the cdb
	function automatic reg_read_t forward(input reg_read_t src);
		reg_read_t res;
		res = '0;
		if (!src.tag_valid) begin
			res.value = src.value;
		end else if (rob_data_ready[src.rob_tag]) begin
			res.value = rob_value[src.rob_tag];
		end else begin
			res.tag_valid = 1'b1;
			res.rob_tag = src.rob_tag;
		end
		return res;
	endfunction

	reg_read_t src1;
	reg_read_t src2;

	always_comb begin
		src1 = forward(rs1_read);
		src2 = forward(rs2_read);
	end

	always_comb begin
		operands = '0;
		// operand 1
		case (stage_q.opcode)
			JAL, AUIPC: begin
				operands.v1 = stage_q.pc;
			end
			R_TYPE, I_ALU, LOAD, JALR, BRANCH, STORE: begin
				operands.q1_valid = src1.tag_valid;
				operands.q1 = src1.rob_tag;
				operands.v1 = src1.value;
			end
			// lui and the nop bubble use a zero base
			default: begin
				operands.v1 = '0;
			end
		endcase
		// operand 2
		case (stage_q.opcode)
			R_TYPE, BRANCH: begin
				operands.q2_valid = src2.tag_valid;
				operands.q2 = src2.rob_tag;
				operands.v2 = src2.value;
			end
			NOP: begin
				operands.v2 = '0;
			end
			default: begin
				operands.v2 = stage_q.immediate;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/rob_data_in_route.sv
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module rob_data_in_route (
	input dispatch_pkg::decoded_t stage_q,
	input dispatch_pkg::reg_read_t rs2_read,
	output dispatch_pkg::rob_entry_t rob_entry
);

	logic [`XLEN-1:0] next_pc;
	logic store_data_ready;
	logic jal;

	// link address steps over a full or a compressed word
	assign next_pc = stage_q.pc + (stage_q.instruction_length ? `XLEN'(4) : `XLEN'(2));

	assign store_data_ready = (stage_q.instruction_type == 2'b11) && !rs2_read.tag_valid;
	assign jal = (stage_q.instruction_type == 2'b01) && !stage_q.ctl_branch
		&& !stage_q.ctl_jalr;

	// jalr still has to resolve its target, so it is not ready yet
	assign rob_entry.data_ready = jal || stage_q.lui || stage_q.auipc || store_data_ready;

	always_comb begin
		if ((stage_q.instruction_type == 2'b01) && !stage_q.ctl_branch) begin
			rob_entry.value = next_pc;
		end else if (stage_q.lui) begin
			rob_entry.value = stage_q.immediate;
		end else if (stage_q.auipc) begin
			rob_entry.value = stage_q.pc + stage_q.immediate;
		end else if (store_data_ready) begin
			rob_entry.value = rs2_read.value;
		end else begin
			// filled in later by the cdb
			rob_entry.value = '0;
		end
	end

endmodule

`default_nettype wire

//--- src/dispatch_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_top (
	input logic clk,
	input logic reset,
	// fetch side
	input logic instr_valid,
	input dispatch_pkg::instr_word_u instr,
	input dispatch_pkg::word_t pc,
	input logic instr_length,
	input logic flush,
	// rob and queues
	input dispatch_pkg::rob_tag_t rob_tail_tag,
	input logic [`ROB_SIZE-1:0][`XLEN-1:0] rob_value,
	input logic [`ROB_SIZE-1:0] rob_data_ready,
	input logic rob_full,
	input logic ldq_full,
	input logic stq_full,
	// reservation station occupancy
	input logic [`N_ALU_RS-1:0] alu_rs_busy,
	input logic [`N_AGU_RS-1:0] agu_rs_busy,
	input logic [`N_BRANCH_RS-1:0] branch_rs_busy,
	// commit port
	input logic commit_valid,
	input dispatch_pkg::reg_idx_t commit_rd,
	input dispatch_pkg::rob_tag_t commit_tag,
	input dispatch_pkg::word_t commit_value,
	output logic alloc_rob_entry,
	output logic alloc_ldq_entry,
	output logic alloc_stq_entry,
	output logic [`N_ALU_RS-1:0] alu_rs_route,
	output logic [`N_AGU_RS-1:0] agu_rs_route,
	output logic [`N_BRANCH_RS-1:0] branch_rs_route,
	output logic stall,
	output dispatch_pkg::operands_t operands,
	output dispatch_pkg::rob_entry_t rob_entry
);

	import dispatch_pkg::*;

	decoded_t stage_q;
	reg_read_t rs1_read;
	reg_read_t rs2_read;

	instr_decode decode_i (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.instr_length(instr_length), .stall(stall), .flush(flush), .stage_q(stage_q)
	);

	// register reads happen in the same cycle as routing
	reg_status_file rsf_i (
		.clk(clk), .reset(reset), .flush(flush), .stage_q(stage_q),
		.alloc_rob_entry(alloc_rob_entry), .rob_tail_tag(rob_tail_tag),
		.commit_valid(commit_valid), .commit_rd(commit_rd), .commit_tag(commit_tag),
		.commit_value(commit_value), .rs1_read(rs1_read), .rs2_read(rs2_read)
	);

	instruction_route iroute_i (
		.stage_q(stage_q), .rob_full(rob_full), .ldq_full(ldq_full), .stq_full(stq_full),
		.flush(flush), .alu_rs_busy(alu_rs_busy), .agu_rs_busy(agu_rs_busy),
		.branch_rs_busy(branch_rs_busy), .alloc_rob_entry(alloc_rob_entry),
		.alloc_ldq_entry(alloc_ldq_entry), .alloc_stq_entry(alloc_stq_entry),
		.alu_rs_route(alu_rs_route), .agu_rs_route(agu_rs_route),
		.branch_rs_route(branch_rs_route), .stall(stall)
	);

	operand_route oroute_i (
		.stage_q(stage_q), .rs1_read(rs1_read), .rs2_read(rs2_read),
		.rob_value(rob_value), .rob_data_ready(rob_data_ready), .operands(operands)
	);

	rob_data_in_route rob_in_i (
		.stage_q(stage_q), .rs2_read(rs2_read), .rob_entry(rob_entry)
	);

endmodule

`default_nettype wire

//--- verification/dispatch_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_tb;

	import dispatch_pkg::*;

	// rough cycle budget per test, the run is cut off past their sum
	localparam int INIT_CYCLES = 70;
	localparam int ROUTE_CYCLES = 400;
	localparam int STALL_CYCLES = 120;
	localparam int DIRECT_CYCLES = 150;
	localparam int RUN_LIMIT = INIT_CYCLES + ROUTE_CYCLES + STALL_CYCLES + DIRECT_CYCLES + 200;

	logic clk = 1'b0;
	logic reset;
	logic instr_valid;
	logic [31:0] instr_word;
	logic [31:0] pc_in;
	logic instr_length;
	logic flush;
	logic [3:0] rob_tail_tag;
	logic [`ROB_SIZE-1:0][`XLEN-1:0] rob_value;
	logic [`ROB_SIZE-1:0] rob_data_ready;
	logic rob_full;
	logic ldq_full;
	logic stq_full;
	logic [2:0] alu_rs_busy;
	logic [1:0] agu_rs_busy;
	logic [1:0] branch_rs_busy;
	logic commit_valid;
	logic [4:0] commit_rd;
	logic [3:0] commit_tag;
	logic [31:0] commit_value;
	logic alloc_rob_entry;
	logic alloc_ldq_entry;
	logic alloc_stq_entry;
	logic [2:0] alu_rs_route;
	logic [1:0] agu_rs_route;
	logic [1:0] branch_rs_route;
	logic stall;
	operands_t operands;
	rob_entry_t rob_entry;

	dispatch_top dut_i (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr_word),
		.pc(pc_in), .instr_length(instr_length), .flush(flush),
		.rob_tail_tag(rob_tail_tag), .rob_value(rob_value), .rob_data_ready(rob_data_ready),
		.rob_full(rob_full), .ldq_full(ldq_full), .stq_full(stq_full),
		.alu_rs_busy(alu_rs_busy), .agu_rs_busy(agu_rs_busy),
		.branch_rs_busy(branch_rs_busy), .commit_valid(commit_valid),
		.commit_rd(commit_rd), .commit_tag(commit_tag), .commit_value(commit_value),
		.alloc_rob_entry(alloc_rob_entry), .alloc_ldq_entry(alloc_ldq_entry),
		.alloc_stq_entry(alloc_stq_entry), .alu_rs_route(alu_rs_route),
		.agu_rs_route(agu_rs_route), .branch_rs_route(branch_rs_route), .stall(stall),
		.operands(operands), .rob_entry(rob_entry)
	);

	always #20 clk = ~clk;

	int error_count = 0;
	int errors_before = 0;
	int tests_run = 0;
	int cycle_count = 0;
	logic [31:0] rng_stim = 32'h4832;
	logic [31:0] rng_busy = 32'h4832 ^ 32'hffff_ffff;
	logic [31:0] rand_pc;
	logic rand_busy = 1'b0;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// r/i/s field layout, hi7 fills the funct7 or upper immediate bits
	function automatic logic [31:0] encode(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [6:0] hi7);
		return {hi7, rs2, rs1, 3'b000, rd, op};
	endfunction

	function automatic logic known_op(input logic [6:0] op);
		return op inside {R_TYPE, I_ALU, LOAD, JALR, BRANCH, STORE, JAL, LUI, AUIPC};
	endfunction

	// immediate per rv32 format, rebuilt from the instruction bits
	function automatic logic [31:0] imm_of(input logic [31:0] w);
		case (w[6:0])
			I_ALU, LOAD, JALR: return {{20{w[31]}}, w[31:20]};
			STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
			BRANCH: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			LUI, AUIPC: return {w[31:12], 12'b0};
			JAL: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: return 32'b0;
		endcase
	endfunction

	// first station whose busy bit is clear, lsb first
	function automatic logic [2:0] first_free(input logic [2:0] busy);
		logic [2:0] pick;
		pick = 3'b000;
		for (int i = 0; i < 3; i++) begin
			if (!busy[i] && (pick == 3'b000)) begin
				pick[i] = 1'b1;
			end
		end
		return pick;
	endfunction

	// reference model of the staged instruction and the register tags
	logic m_valid = 1'b0;
	logic [31:0] m_word = '0;
	logic [31:0] m_pc = '0;
	logic m_len = 1'b0;
	logic [31:0] m_reg [32];
	logic [3:0] m_tag [32];
	logic [31:0] m_tagv = '0;

	initial begin
		for (int i = 0; i < 32; i++) begin
			m_reg[i] = '0;
			m_tag[i] = '0;
		end
	end

	// source after rob forwarding, as the station should see it
	function automatic reg_read_t forwarded(input logic [4:0] idx);
		reg_read_t r;
		r = '0;
		if (!m_tagv[idx]) begin
			r.value = m_reg[idx];
		end else if (rob_data_ready[m_tag[idx]]) begin
			r.value = rob_value[m_tag[idx]];
		end else begin
			r.tag_valid = 1'b1;
			r.rob_tag = m_tag[idx];
		end
		return r;
	endfunction

	logic [6:0] m_op;
	logic [4:0] m_rd;
	logic [4:0] m_rs1;
	logic [4:0] m_rs2;
	logic [31:0] m_imm;
	logic cls_alu;
	logic cls_agu;
	logic cls_branch;
	logic has_rd;
	logic stall_cond;
	logic issue_ok;
	logic exp_stall;
	logic exp_alloc_rob;
	logic exp_alloc_ldq;
	logic exp_alloc_stq;
	logic [2:0] exp_alu_route;
	logic [1:0] exp_agu_route;
	logic [1:0] exp_branch_route;
	reg_read_t src1;
	reg_read_t src2;
	operands_t exp_ops;
	rob_entry_t exp_rob;

	assign m_op = m_word[6:0];
	assign m_rd = m_word[11:7];
	assign m_rs1 = m_word[19:15];
	assign m_rs2 = m_word[24:20];
	assign m_imm = imm_of(m_word);

	always_comb begin
		cls_alu = (m_op == R_TYPE) || (m_op == I_ALU);
		cls_agu = (m_op == LOAD) || (m_op == STORE);
		cls_branch = (m_op == BRANCH) || (m_op == JALR);
		has_rd = (m_op != BRANCH) && (m_op != STORE);
		// every instruction needs a rob entry, loads and stores their queue too
		stall_cond = rob_full || ((m_op == LOAD) && ldq_full)
			|| ((m_op == STORE) && stq_full) || (cls_alu && (&alu_rs_busy))
			|| (cls_agu && (&agu_rs_busy)) || (cls_branch && (&branch_rs_busy));
		exp_stall = m_valid && stall_cond;
		issue_ok = m_valid && !flush && !stall_cond;
		exp_alloc_rob = issue_ok;
		exp_alloc_ldq = issue_ok && (m_op == LOAD);
		exp_alloc_stq = issue_ok && (m_op == STORE);
		exp_alu_route = (issue_ok && cls_alu) ? first_free(alu_rs_busy) : 3'b000;
		exp_agu_route = 2'b00;
		exp_branch_route = 2'b00;
		if (issue_ok && cls_agu) begin
			exp_agu_route = 2'(first_free({1'b1, agu_rs_busy}));
		end
		if (issue_ok && cls_branch) begin
			exp_branch_route = 2'(first_free({1'b1, branch_rs_busy}));
		end
		// operand selection
		src1 = forwarded(m_rs1);
		src2 = forwarded(m_rs2);
		exp_ops = '0;
		if ((m_op == JAL) || (m_op == AUIPC)) begin
			exp_ops.v1 = m_pc;
		end else if (m_op != LUI) begin
			exp_ops.q1_valid = src1.tag_valid;
			exp_ops.q1 = src1.rob_tag;
			exp_ops.v1 = src1.value;
		end
		if ((m_op == R_TYPE) || (m_op == BRANCH)) begin
			exp_ops.q2_valid = src2.tag_valid;
			exp_ops.q2 = src2.rob_tag;
			exp_ops.v2 = src2.value;
		end else begin
			exp_ops.v2 = m_imm;
		end
		// value written into the rob at allocation
		exp_rob = '0;
		if ((m_op == JAL) || (m_op == JALR)) begin
			exp_rob.value = m_pc + (m_len ? 32'd4 : 32'd2);
			exp_rob.data_ready = (m_op == JAL);
		end else if (m_op == LUI) begin
			exp_rob.value = m_imm;
			exp_rob.data_ready = 1'b1;
		end else if (m_op == AUIPC) begin
			exp_rob.value = m_pc + m_imm;
			exp_rob.data_ready = 1'b1;
		end else if ((m_op == STORE) && !m_tagv[m_rs2]) begin
			exp_rob.value = m_reg[m_rs2];
			exp_rob.data_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		if (reset || flush) begin
			m_valid <= 1'b0;
		end else if (!exp_stall) begin
			m_valid <= instr_valid && known_op(instr_word[6:0]);
			m_word <= instr_word;
			m_pc <= pc_in;
			m_len <= instr_length;
		end
		if (commit_valid && (commit_rd != 5'd0)) begin
			m_reg[commit_rd] <= commit_value;
		end
		if (exp_alloc_rob && has_rd && (m_rd != 5'd0)) begin
			m_tag[m_rd] <= rob_tail_tag;
		end
		if (reset || flush) begin
			m_tagv <= '0;
		end else begin
			if (commit_valid && m_tagv[commit_rd] && (m_tag[commit_rd] == commit_tag)) begin
				m_tagv[commit_rd] <= 1'b0;
			end
			// a new tag beats a commit to the same register
			if (exp_alloc_rob && has_rd && (m_rd != 5'd0)) begin
				m_tagv[m_rd] <= 1'b1;
			end
		end
	end

	task automatic report_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		error_count++;
		$display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic report_msg(input string what);
		error_count++;
		$display("at %0t: %s", $time, what);
	endtask

	check_stall: assert property (@(posedge clk) disable iff (reset) stall == exp_stall)
		else report_value("stall", 128'($sampled(stall)), 128'($sampled(exp_stall)));
	check_alloc_rob: assert property (@(posedge clk) disable iff (reset)
		alloc_rob_entry == exp_alloc_rob)
		else report_value("alloc_rob_entry", 128'($sampled(alloc_rob_entry)),
			128'($sampled(exp_alloc_rob)));
	check_alloc_ldq: assert property (@(posedge clk) disable iff (reset)
		alloc_ldq_entry == exp_alloc_ldq)
		else report_value("alloc_ldq_entry", 128'($sampled(alloc_ldq_entry)),
			128'($sampled(exp_alloc_ldq)));
	check_alloc_stq: assert property (@(posedge clk) disable iff (reset)
		alloc_stq_entry == exp_alloc_stq)
		else report_value("alloc_stq_entry", 128'($sampled(alloc_stq_entry)),
			128'($sampled(exp_alloc_stq)));
	check_alu_route: assert property (@(posedge clk) disable iff (reset)
		alu_rs_route == exp_alu_route)
		else report_value("alu_rs_route", 128'($sampled(alu_rs_route)),
			128'($sampled(exp_alu_route)));
	check_agu_route: assert property (@(posedge clk) disable iff (reset)
		agu_rs_route == exp_agu_route)
		else report_value("agu_rs_route", 128'($sampled(agu_rs_route)),
			128'($sampled(exp_agu_route)));
	check_branch_route: assert property (@(posedge clk) disable iff (reset)
		branch_rs_route == exp_branch_route)
		else report_value("branch_rs_route", 128'($sampled(branch_rs_route)),
			128'($sampled(exp_branch_route)));
	// operands and rob value only mean something for a valid staged instruction
	check_operands: assert property (@(posedge clk) disable iff (reset)
		m_valid |-> operands == exp_ops)
		else report_value("operands", 128'($sampled(operands)), 128'($sampled(exp_ops)));
	check_rob_entry: assert property (@(posedge clk) disable iff (reset)
		m_valid |-> rob_entry == exp_rob)
		else report_value("rob_entry", 128'($sampled(rob_entry)), 128'($sampled(exp_rob)));
	check_flush_quiet: assert property (@(posedge clk) disable iff (reset)
		flush |-> !(alloc_rob_entry || alloc_ldq_entry || alloc_stq_entry
			|| (|alu_rs_route) || (|agu_rs_route) || (|branch_rs_route)))
		else report_msg("a strobe or route fired during flush");
	check_stall_quiet: assert property (@(posedge clk) disable iff (reset)
		stall |-> !(alloc_rob_entry || alloc_ldq_entry || alloc_stq_entry
			|| (|alu_rs_route) || (|agu_rs_route) || (|branch_rs_route)))
		else report_msg("a strobe or route fired while stalled");

	// random station occupancy, new every cycle while enabled
	always @(posedge clk) begin
		if (rand_busy) begin
			rng_busy = xorshift(rng_busy);
			alu_rs_busy <= rng_busy[2:0];
			agu_rs_busy <= rng_busy[4:3];
			branch_rs_busy <= rng_busy[6:5];
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= RUN_LIMIT) begin
			$display("run did not finish within %0d cycles", RUN_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// present one word, hold it until accepted, then give the rob tail tag
	task automatic issue(input logic [31:0] word, input logic [31:0] at_pc,
		input logic len, input logic [3:0] tag);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr_word <= word;
		pc_in <= at_pc;
		instr_length <= len;
		do @(negedge clk); while (stall);
		@(posedge clk);
		instr_valid <= 1'b0;
		rob_tail_tag <= tag;
	endtask

	task automatic commit(input logic [4:0] rd, input logic [3:0] tag, input logic [31:0] val);
		@(posedge clk);
		commit_valid <= 1'b1;
		commit_rd <= rd;
		commit_tag <= tag;
		commit_value <= val;
		@(posedge clk);
		commit_valid <= 1'b0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("%s done, %0d failed checks", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	logic [6:0] op_list [9] = '{R_TYPE, I_ALU, LOAD, JALR, BRANCH, STORE, JAL, LUI, AUIPC};
	logic [6:0] stall_ops [6] = '{I_ALU, LOAD, STORE, R_TYPE, LOAD, BRANCH};

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instr_word = '0;
		pc_in = '0;
		instr_length = 1'b1;
		flush = 1'b0;
		rob_tail_tag = '0;
		rob_full = 1'b0;
		ldq_full = 1'b0;
		stq_full = 1'b0;
		alu_rs_busy = '0;
		agu_rs_busy = '0;
		branch_rs_busy = '0;
		commit_valid = 1'b0;
		commit_rd = '0;
		commit_tag = '0;
		commit_value = '0;
		// even rob entries are ready, odd ones still wait on the cdb
		rob_data_ready = 16'h5555;
		for (int i = 0; i < `ROB_SIZE; i++) begin
			rng_stim = xorshift(rng_stim);
			rob_value[i] = rng_stim;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// fill the register file through the commit port
		for (int r = 1; r < 32; r++) begin
			rng_stim = xorshift(rng_stim);
			commit(5'(r), 4'd0, rng_stim);
		end
		end_test("register load");

		rand_busy <= 1'b1;
		for (int n = 0; n < 60; n++) begin
			rng_stim = xorshift(rng_stim);
			rand_pc = xorshift(rng_stim);
			issue({rng_stim[31:7], op_list[int'(rng_stim % 32'd9)]},
				{rand_pc[31:1], 1'b0}, rng_stim[9], rng_stim[13:10]);
		end
		// an opcode outside the subset becomes a bubble and routes nowhere
		issue(encode(7'h7b, 5'd3, 5'd1, 5'd2, 7'h00), 32'h80, 1'b1, 4'd0);
		@(posedge clk);
		rand_busy <= 1'b0;
		@(posedge clk);
		alu_rs_busy <= '0;
		agu_rs_busy <= '0;
		branch_rs_busy <= '0;
		end_test("class routing");

		for (int k = 0; k < 6; k++) begin
			@(posedge clk);
			rob_full <= (k == 0);
			ldq_full <= (k == 1);
			stq_full <= (k == 2);
			alu_rs_busy <= (k == 3) ? 3'b111 : 3'b000;
			agu_rs_busy <= (k == 4) ? 2'b11 : 2'b00;
			branch_rs_busy <= (k == 5) ? 2'b11 : 2'b00;
			issue(encode(stall_ops[k], 5'd20, 5'd1, 5'd2, 7'h11), 32'h100, 1'b1, 4'd14);
			// a second word waits behind the stalled one
			@(posedge clk);
			instr_valid <= 1'b1;
			instr_word <= encode(I_ALU, 5'd21, 5'd3, 5'd0, 7'h05);
			repeat (5) @(posedge clk);
			rob_full <= 1'b0;
			ldq_full <= 1'b0;
			stq_full <= 1'b0;
			alu_rs_busy <= '0;
			agu_rs_busy <= '0;
			branch_rs_busy <= '0;
			do @(negedge clk); while (stall);
			@(posedge clk);
			instr_valid <= 1'b0;
		end
		end_test("stall");

		// x6 waits on ready entry 2, x7 on entry 3 which is not ready
		issue(encode(I_ALU, 5'd6, 5'd1, 5'd0, 7'h01), 32'h200, 1'b1, 4'd2);
		issue(encode(I_ALU, 5'd7, 5'd1, 5'd0, 7'h02), 32'h204, 1'b1, 4'd3);
		issue(encode(R_TYPE, 5'd8, 5'd6, 5'd7, 7'h00), 32'h208, 1'b1, 4'd4);
		issue(encode(R_TYPE, 5'd9, 5'd12, 5'd13, 7'h20), 32'h20c, 1'b1, 4'd6);
		issue(encode(BRANCH, 5'd5, 5'd7, 5'd6, 7'h40), 32'h210, 1'b1, 4'd8);
		issue(encode(AUIPC, 5'd14, 5'd7, 5'd9, 7'h3c), 32'h214, 1'b0, 4'd10);
		issue(encode(LUI, 5'd15, 5'd7, 5'd9, 7'h7f), 32'h218, 1'b1, 4'd12);
		end_test("operands");

		issue(encode(JAL, 5'd1, 5'd30, 5'd31, 7'h55), 32'h300, 1'b1, 4'd0);
		issue(encode(JAL, 5'd16, 5'd30, 5'd31, 7'h2a), 32'h306, 1'b0, 4'd1);
		issue(encode(JALR, 5'd17, 5'd18, 5'd0, 7'h0f), 32'h30a, 1'b0, 4'd2);
		issue(encode(STORE, 5'd3, 5'd18, 5'd19, 7'h12), 32'h30e, 1'b1, 4'd4);
		issue(encode(STORE, 5'd3, 5'd18, 5'd7, 7'h12), 32'h312, 1'b1, 4'd5);
		issue(encode(STORE, 5'd3, 5'd18, 5'd0, 7'h12), 32'h316, 1'b1, 4'd6);
		end_test("rob entry value");

		issue(encode(I_ALU, 5'd10, 5'd2, 5'd0, 7'h03), 32'h400, 1'b1, 4'd5);
		issue(encode(R_TYPE, 5'd22, 5'd10, 5'd10, 7'h00), 32'h404, 1'b1, 4'd7);
		// stale tag, x10 stays pending on entry 5
		commit(5'd10, 4'd4, 32'hdead_0004);
		issue(encode(R_TYPE, 5'd23, 5'd10, 5'd2, 7'h00), 32'h408, 1'b1, 4'd9);
		commit(5'd10, 4'd5, 32'hbeef_0005);
		issue(encode(R_TYPE, 5'd24, 5'd10, 5'd2, 7'h00), 32'h40c, 1'b1, 4'd11);
		issue(encode(I_ALU, 5'd0, 5'd2, 5'd0, 7'h03), 32'h410, 1'b1, 4'd1);
		issue(encode(R_TYPE, 5'd25, 5'd0, 5'd0, 7'h00), 32'h414, 1'b1, 4'd13);
		end_test("tags and commit");

		issue(encode(I_ALU, 5'd12, 5'd2, 5'd0, 7'h03), 32'h500, 1'b1, 4'd9);
		issue(encode(I_ALU, 5'd11, 5'd2, 5'd0, 7'h03), 32'h504, 1'b1, 4'd11);
		// flush lands while x11's instruction sits in the stage
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		issue(encode(R_TYPE, 5'd26, 5'd12, 5'd11, 7'h00), 32'h508, 1'b1, 4'd3);
		issue(encode(R_TYPE, 5'd27, 5'd22, 5'd24, 7'h00), 32'h50c, 1'b1, 4'd5);
		repeat (2) @(posedge clk);
		end_test("flush");

		$display("%0d tests run, %0d failed checks", tests_run, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
src/dispatch_pkg.sv
src/instr_decode.sv
src/reg_status_file.sv
src/instruction_route.sv
src/operand_route.sv
src/rob_data_in_route.sv
src/dispatch_top.sv
verification/dispatch_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS = --timing --assert
TOP = dispatch_tb
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
